// File: hdl/bubble_params.svh
`ifndef BUBBLE_PARAMS_SVH
`define BUBBLE_PARAMS_SVH

// blinker half period in MCLK cycles, short for simulation
`define BLINK_HALF      16

// TC77 polling
`define TEMP_POLL       512
`define TEMP_SCLK_DIV   2

// warm-up thresholds, temp codes in 1/16 degC
// 10 degC, 15 degC, 20 degC
`define WARM_THR1       160
`define WARM_THR2       240
`define WARM_THR3       320

// fan on at 40 degC, off 2 degC lower
`define FAN_THR         640
`define FAN_HYST        32

`endif

// File: hdl/bubble_pkg.sv
`default_nettype none

package bubble_pkg;

    // TC77 reading, signed, 1/16 degC per lsb
    typedef logic signed [12:0] temp_code_t;

    // latched DIP word
    // [5] wide bus, [4] reserved, [3] storage type, [2] fan enable, [1:0] delay level
    typedef logic [5:0] settings_t;

    // warm-up level, 0 = no warm-up
    typedef logic [1:0] delay_lvl_t;

    // startup machine
    typedef enum logic [2:0] {
        st_reset,
        st_select,
        st_emulate,
        st_usb_standby,
        st_err_board,
        st_err_usb
    } sys_mode_t;

endpackage

`default_nettype wire

// File: hdl/mode_control.sv
`timescale 1ns/10ps
`default_nettype none

module mode_control
(
    input  wire                     MCLK,
    input  wire                     MRST,
    input  wire                     usb_pwr,
    input  wire                     board_fault,
    input  wire         [3:0]       settings_sw,
    input  wire         [1:0]       delay_sw,
    input  wire                     delaying,
    input  wire                     temp_low,
    input  wire                     blink,
    output bubble_pkg::delay_lvl_t  delay_lvl,
    output logic                    fan_allow,
    output logic                    guard_en,
    output logic                    blink_run,
    output logic                    wide_bus,
    output logic                    drive_ready,
    output logic                    led_pwrok_n,
    output logic                    led_standby_n,
    output logic                    led_delaying_n
);

    import bubble_pkg::*;

    sys_mode_t      state;
    settings_t      settings_q;
    logic   [1:0]   pwr_pair;

    // active-low LED controls
    logic           pwrok_off;
    logic           standby_off;
    logic           delay_off;

    assign pwr_pair = {usb_pwr, board_fault};

    ////////////////////////////////////////
    // startup machine
    ////////////////////////////////////////

    always_ff @(posedge MCLK)
    begin
        if (MRST)
            state <= st_reset;
        else
        begin
            case (state)
                st_reset:
                    state <= st_select;
                st_select:
                begin
                    case (pwr_pair)
                        2'b00:   state <= st_emulate;
                        2'b01:   state <= st_err_board;
                        2'b10:   state <= st_err_usb;
                        default: state <= st_usb_standby;
                    endcase
                end
                // held until MRST
                st_emulate:
                    state <= st_emulate;
                st_usb_standby:
                    if (pwr_pair != 2'b11)
                        state <= st_reset;
                st_err_board:
                    if (pwr_pair != 2'b01)
                        state <= st_reset;
                st_err_usb:
                    if (pwr_pair != 2'b10)
                        state <= st_reset;
                default:
                    state <= st_reset;
            endcase
        end
    end

    // switches are active low on the board
    always_ff @(posedge MCLK)
    begin
        if (state == st_reset)
            settings_q <= {~settings_sw, ~delay_sw};
    end

    assign delay_lvl = settings_q[1:0];
    assign fan_allow = settings_q[2];
    assign wide_bus  = settings_q[5];

    ////////////////////////////////////////
    // LED and enable registers
    ////////////////////////////////////////

    always_ff @(posedge MCLK)
    begin
        if (MRST)
        begin
            guard_en    <= 1'b0;
            blink_run   <= 1'b0;
            pwrok_off   <= 1'b1;
            standby_off <= 1'b1;
            delay_off   <= 1'b1;
        end
        else
        begin
            guard_en    <= (state == st_emulate);
            blink_run   <= (state == st_usb_standby) || (state == st_err_board)
                           || (state == st_err_usb);
            pwrok_off   <= !((state == st_emulate) || (state == st_usb_standby));
            standby_off <= (state != st_usb_standby);
            delay_off   <= (state != st_emulate);
        end
    end

    // steady when control is low, blinking when high and blinker runs
    assign led_pwrok_n    = pwrok_off & blink;
    assign led_standby_n  = (standby_off | blink) & ~delaying;
    // delay LED also marks a cold board
    assign led_delaying_n = delay_off | ~(delaying | temp_low);
    assign drive_ready    = guard_en & ~delaying;

    a_guard_en_emulate: assert property (@(posedge MCLK) disable iff (MRST)
        guard_en |-> state == st_emulate)
        else $error("guard enable high outside emulate mode");

endmodule

`default_nettype wire

// File: hdl/status_blinker.sv
`timescale 1ns/10ps
`default_nettype none

module status_blinker
(
    input  wire     MCLK,
    input  wire     MRST,
    input  wire     run,
    output logic    blink
);

    `include "bubble_params.svh"

    localparam int CW = $clog2(`BLINK_HALF + 1);

    typedef enum logic {bl_stop, bl_run} bl_state_t;

    bl_state_t          state;
    logic   [CW-1:0]    half_cnt;

    always_ff @(posedge MCLK)
    begin
        if (MRST)
        begin
            state    <= bl_stop;
            half_cnt <= '0;
            blink    <= 1'b1;
        end
        else
        begin
            state <= run ? bl_run : bl_stop;
            if (state == bl_stop)
            begin
                // LED off while stopped
                half_cnt <= '0;
                blink    <= 1'b1;
            end
            else if (half_cnt == CW'(`BLINK_HALF))
            begin
                half_cnt <= '0;
                blink    <= ~blink;
            end
            else
                half_cnt <= half_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/tc77_reader.sv
`timescale 1ns/10ps
`default_nettype none

module tc77_reader
(
    input  wire                     MCLK,
    input  wire                     MRST,
    input  wire                     temp_sio_in,
    output logic                    temp_cs_n,
    output logic                    temp_sclk,
    output logic                    temp_valid,
    output bubble_pkg::temp_code_t  temp_code
);

    import bubble_pkg::*;

    `include "bubble_params.svh"

    localparam int PW = $clog2(`TEMP_POLL);
    localparam int DW = $clog2(`TEMP_SCLK_DIV + 1);

    typedef enum logic [1:0] {rd_idle, rd_shift, rd_done} rd_state_t;

    rd_state_t          state;
    logic   [PW-1:0]    poll_cnt;
    logic   [DW-1:0]    div_cnt;
    // 32 half periods of the serial clock
    logic   [4:0]       half_cnt;
    logic   [15:0]      shift_q;
    logic               poll_hit;

    ////////////////////////////////////////
    // poll timer
    ////////////////////////////////////////

    assign poll_hit = (poll_cnt == PW'(`TEMP_POLL - 1));

    always_ff @(posedge MCLK)
    begin
        if (MRST || poll_hit)
            poll_cnt <= '0;
        else
            poll_cnt <= poll_cnt + 1'b1;
    end

    ////////////////////////////////////////
    // serial read
    ////////////////////////////////////////

    always_ff @(posedge MCLK)
    begin
        if (MRST)
        begin
            state      <= rd_idle;
            temp_cs_n  <= 1'b1;
            temp_sclk  <= 1'b0;
            temp_valid <= 1'b0;
            div_cnt    <= '0;
            half_cnt   <= '0;
        end
        else
        begin
            temp_valid <= 1'b0;
            case (state)
                rd_idle:
                begin
                    div_cnt  <= '0;
                    half_cnt <= '0;
                    if (poll_hit)
                    begin
                        temp_cs_n <= 1'b0;
                        state     <= rd_shift;
                    end
                end
                rd_shift:
                begin
                    if (div_cnt == DW'(`TEMP_SCLK_DIV - 1))
                    begin
                        div_cnt   <= '0;
                        temp_sclk <= ~temp_sclk;
                        half_cnt  <= half_cnt + 1'b1;
                        // last falling edge ends the frame
                        if (half_cnt == 5'd31)
                        begin
                            temp_cs_n <= 1'b1;
                            state     <= rd_done;
                        end
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;
                end
                rd_done:
                begin
                    temp_valid <= 1'b1;
                    state      <= rd_idle;
                end
                default:
                    state <= rd_idle;
            endcase
        end
    end

    // MSB first, sampled on rising sclk
    always_ff @(posedge MCLK)
    begin
        if (state == rd_shift && div_cnt == DW'(`TEMP_SCLK_DIV - 1) && !temp_sclk)
            shift_q <= {shift_q[14:0], temp_sio_in};
        if (state == rd_done)
            temp_code <= temp_code_t'(shift_q[15:3]);
    end

    a_valid_cs_high: assert property (@(posedge MCLK) disable iff (MRST)
        temp_valid |-> temp_cs_n)
        else $error("sample strobe during an active sensor frame");

endmodule

`default_nettype wire

// File: hdl/thermal_guard.sv
`timescale 1ns/10ps
`default_nettype none

module thermal_guard
(
    input  wire                         MCLK,
    input  wire                         MRST,
    input  wire                         en,
    input  wire bubble_pkg::delay_lvl_t delay_lvl,
    input  wire                         fan_allow,
    input  wire                         force_start,
    input  wire                         temp_valid,
    input  wire bubble_pkg::temp_code_t temp_code,
    output logic                        delaying,
    output logic                        temp_low,
    output logic                        fan_n
);

    import bubble_pkg::*;

    `include "bubble_params.svh"

    localparam temp_code_t FAN_ON  = temp_code_t'(`FAN_THR);
    localparam temp_code_t FAN_OFF = temp_code_t'(`FAN_THR - `FAN_HYST);

    temp_code_t     warm_thr;
    logic           low_now;
    logic           en_q;
    // waiting for the first sample after enable
    logic           first_pending;

    always_comb
    begin
        case (delay_lvl)
            2'd1:    warm_thr = temp_code_t'(`WARM_THR1);
            2'd2:    warm_thr = temp_code_t'(`WARM_THR2);
            default: warm_thr = temp_code_t'(`WARM_THR3);
        endcase
    end

    assign low_now = (delay_lvl != 2'd0) && (temp_code < warm_thr);

    always_ff @(posedge MCLK)
    begin
        if (MRST)
        begin
            en_q          <= 1'b0;
            first_pending <= 1'b0;
            delaying      <= 1'b0;
            temp_low      <= 1'b0;
            fan_n         <= 1'b1;
        end
        else
        begin
            en_q <= en;
            if (!en || force_start)
            begin
                first_pending <= 1'b0;
                delaying      <= 1'b0;
            end
            else if (!en_q)
                first_pending <= 1'b1;
            else if (temp_valid)
            begin
                first_pending <= 1'b0;
                if (first_pending && low_now)
                    delaying <= 1'b1;
                else if (!low_now)
                    delaying <= 1'b0;
            end

            if (temp_valid)
            begin
                temp_low <= low_now;
                // hysteresis band keeps the fan where it is
                if (fan_allow && temp_code >= FAN_ON)
                    fan_n <= 1'b0;
                else if (!fan_allow || temp_code < FAN_OFF)
                    fan_n <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/bubble_sys_top.sv
`timescale 1ns/10ps
`default_nettype none

module bubble_sys_top
(
    input  wire             MCLK,
    input  wire             MRST,
    input  wire             usb_pwr,
    input  wire             board_fault,
    input  wire     [3:0]   settings_sw,
    input  wire     [1:0]   delay_sw,
    input  wire             force_start,
    input  wire             temp_sio,
    output logic            temp_cs_n,
    output logic            temp_sclk,
    output logic            fan_n,
    output logic            temp_lo,
    output logic            wide_bus_n,
    output logic            drive_ready,
    output logic            led_pwrok_n,
    output logic            led_standby_n,
    output logic            led_delaying_n
);

    import bubble_pkg::*;

    delay_lvl_t     delay_lvl;
    temp_code_t     temp_code;
    logic           fan_allow;
    logic           guard_en;
    logic           blink_run;
    logic           blink;
    logic           wide_bus;
    logic           delaying;
    logic           temp_valid;

    // 4-bit bus select pin is active low
    assign wide_bus_n = ~wide_bus;

    mode_control u_mode_control
    (
        .MCLK           (MCLK),
        .MRST           (MRST),
        .usb_pwr        (usb_pwr),
        .board_fault    (board_fault),
        .settings_sw    (settings_sw),
        .delay_sw       (delay_sw),
        .delaying       (delaying),
        .temp_low       (temp_lo),
        .blink          (blink),
        .delay_lvl      (delay_lvl),
        .fan_allow      (fan_allow),
        .guard_en       (guard_en),
        .blink_run      (blink_run),
        .wide_bus       (wide_bus),
        .drive_ready    (drive_ready),
        .led_pwrok_n    (led_pwrok_n),
        .led_standby_n  (led_standby_n),
        .led_delaying_n (led_delaying_n)
    );

    status_blinker u_status_blinker
    (
        .MCLK           (MCLK),
        .MRST           (MRST),
        .run            (blink_run),
        .blink          (blink)
    );

    tc77_reader u_tc77_reader
    (
        .MCLK           (MCLK),
        .MRST           (MRST),
        .temp_sio_in    (temp_sio),
        .temp_cs_n      (temp_cs_n),
        .temp_sclk      (temp_sclk),
        .temp_valid     (temp_valid),
        .temp_code      (temp_code)
    );

    thermal_guard u_thermal_guard
    (
        .MCLK           (MCLK),
        .MRST           (MRST),
        .en             (guard_en),
        .delay_lvl      (delay_lvl),
        .fan_allow      (fan_allow),
        .force_start    (force_start),
        .temp_valid     (temp_valid),
        .temp_code      (temp_code),
        .delaying       (delaying),
        .temp_low       (temp_lo),
        .fan_n          (fan_n)
    );

endmodule

`default_nettype wire

// File: sim/tb_tc77_model.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tc77_model
(
    input  wire                         cs_n,
    input  wire                         sclk,
    input  wire bubble_pkg::temp_code_t temp,
    output logic                        sio
);

    logic   [15:0]  frame = 16'hffff;

    assign sio = frame[15];

    // frame loaded at chip select fall, bit 2 flags a finished conversion
    // next bit goes out on each falling serial clock
    always
    begin
        @(negedge cs_n);
        frame = {temp, 3'b100};
        repeat (15)
        begin
            @(negedge sclk);
            frame = {frame[14:0], 1'b0};
        end
        // last falling edge comes with chip select high
        @(posedge cs_n);
    end

endmodule

`default_nettype wire

// File: sim/tb_bubble_sys.sv
`timescale 1ns/10ps
`default_nettype none

module tb_bubble_sys;

    import bubble_pkg::*;

    `include "bubble_params.svh"

    localparam int SEL_PWROK    = 0;
    localparam int SEL_STANDBY  = 1;
    localparam int SEL_DELAY    = 2;
    localparam int SEL_READY    = 3;
    localparam int SEL_CS       = 4;

    localparam int BLINK_STEP   = `BLINK_HALF + 1;
    localparam int SETTLE_LIMIT = 3 * BLINK_STEP + 10;
    localparam int BLINK_LIMIT  = 2 * BLINK_STEP + 4;
    // 16 serial clocks plus a few cycles of margin
    localparam int FRAME_LIMIT  = 32 * `TEMP_SCLK_DIV + 8;

    logic           MCLK;
    logic           MRST;
    logic           usb_pwr;
    logic           board_fault;
    logic   [3:0]   settings_sw;
    logic   [1:0]   delay_sw;
    logic           force_start;
    wire            temp_sio;
    wire            temp_cs_n;
    wire            temp_sclk;
    wire            fan_n;
    wire            temp_lo;
    wire            wide_bus_n;
    wire            drive_ready;
    wire            led_pwrok_n;
    wire            led_standby_n;
    wire            led_delaying_n;

    temp_code_t     model_temp;
    logic   [31:0]  rng_state = 32'h46b4_e687;

    bubble_sys_top uut
    (
        .MCLK           (MCLK),
        .MRST           (MRST),
        .usb_pwr        (usb_pwr),
        .board_fault    (board_fault),
        .settings_sw    (settings_sw),
        .delay_sw       (delay_sw),
        .force_start    (force_start),
        .temp_sio       (temp_sio),
        .temp_cs_n      (temp_cs_n),
        .temp_sclk      (temp_sclk),
        .fan_n          (fan_n),
        .temp_lo        (temp_lo),
        .wide_bus_n     (wide_bus_n),
        .drive_ready    (drive_ready),
        .led_pwrok_n    (led_pwrok_n),
        .led_standby_n  (led_standby_n),
        .led_delaying_n (led_delaying_n)
    );

    tb_tc77_model sensor
    (
        .cs_n   (temp_cs_n),
        .sclk   (temp_sclk),
        .temp   (model_temp),
        .sio    (temp_sio)
    );

    initial
    begin
        MCLK = 1'b0;
        forever #10 MCLK = ~MCLK;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_below(input int span);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % span);
    endfunction

    function automatic logic probe(input int sel);
        case (sel)
            SEL_PWROK:   return led_pwrok_n;
            SEL_STANDBY: return led_standby_n;
            SEL_DELAY:   return led_delaying_n;
            SEL_READY:   return drive_ready;
            default:     return temp_cs_n;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic compare_values(input logic [31:0] actual, input logic [31:0] expected,
                                  input string what);
        if (actual !== expected)
            abort_run($sformatf("Mismatch at %0t: %s, got %0h expected %0h",
                                $time, what, actual, expected));
    endtask

    task automatic wait_for_level(input int sel, input logic level, input int limit,
                                  input string what);
        int waited;
        waited = 0;
        while (probe(sel) !== level)
        begin
            if (waited == limit)
                abort_run($sformatf("Timed out after %0d cycles waiting for %s", limit, what));
            @(negedge MCLK);
            waited++;
        end
    endtask

    task automatic wait_for_change(input int sel, input int limit, input string what,
                                   output int gap);
        logic start;
        start = probe(sel);
        gap = 0;
        while (probe(sel) === start)
        begin
            if (gap == limit)
                abort_run($sformatf("Timed out after %0d cycles waiting for %s", limit, what));
            @(negedge MCLK);
            gap++;
        end
    endtask

    task automatic hold_steady(input int sel, input logic level, input int cycles,
                               input string what);
        repeat (cycles)
        begin
            compare_values(probe(sel), level, what);
            @(negedge MCLK);
        end
    endtask

    // reset with new power inputs, switches and sensor temperature
    task automatic apply_reset(input logic usb, input logic fault, input logic [3:0] sw,
                               input logic [1:0] dly, input int temp);
        @(negedge MCLK);
        MRST        = 1'b1;
        usb_pwr     = usb;
        board_fault = fault;
        settings_sw = sw;
        delay_sw    = dly;
        force_start = 1'b0;
        model_temp  = temp_code_t'(temp);
        repeat (5) @(negedge MCLK);
        compare_values(led_pwrok_n, 1'b1, "power LED off in reset");
        compare_values(led_standby_n, 1'b1, "standby LED off in reset");
        compare_values(led_delaying_n, 1'b1, "delay LED off in reset");
        compare_values(drive_ready, 1'b0, "drive not ready in reset");
        compare_values(fan_n, 1'b1, "fan off in reset");
        compare_values(temp_cs_n, 1'b1, "sensor deselected in reset");
        MRST = 1'b0;
        // lit steady, or first low phase of the blink in the error modes
        wait_for_level(SEL_PWROK, 1'b0, SETTLE_LIMIT, "power LED after reset");
    endtask

    // one full sensor frame, then strobe and guard update
    task automatic next_sample();
        int   rises;
        int   cycles;
        logic sclk_prev;
        wait_for_level(SEL_CS, 1'b0, `TEMP_POLL + 8, "sensor frame start");
        rises     = 0;
        cycles    = 0;
        sclk_prev = temp_sclk;
        while (temp_cs_n !== 1'b1)
        begin
            if (cycles == FRAME_LIMIT)
                abort_run($sformatf("Timed out after %0d cycles waiting for %s",
                                    FRAME_LIMIT, "sensor frame end"));
            @(negedge MCLK);
            cycles++;
            if (sclk_prev === 1'b0 && temp_sclk === 1'b1)
                rises++;
            sclk_prev = temp_sclk;
        end
        compare_values(rises, 16, "serial clocks per sensor frame");
        compare_values(cycles, 32 * `TEMP_SCLK_DIV, "sensor frame length");
        repeat (3) @(negedge MCLK);
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic mode_select_cases();
        // emulate
        apply_reset(1'b0, 1'b0, 4'b1111, 2'b11, 400);
        compare_values(wide_bus_n, 1'b1, "narrow bus selected");
        compare_values(drive_ready, 1'b1, "drive ready in emulate");
        hold_steady(SEL_PWROK, 1'b0, BLINK_LIMIT, "power LED steady in emulate");
        // board error
        apply_reset(1'b0, 1'b1, 4'b1111, 2'b11, 400);
        compare_values(drive_ready, 1'b0, "drive idle in board error");
        wait_for_level(SEL_PWROK, 1'b1, BLINK_LIMIT, "power LED blink in board error");
        // ambiguous power
        apply_reset(1'b1, 1'b0, 4'b1111, 2'b11, 400);
        compare_values(drive_ready, 1'b0, "drive idle in ambiguous power error");
        wait_for_level(SEL_PWROK, 1'b1, BLINK_LIMIT, "power LED blink in ambiguous error");
        // USB standby
        apply_reset(1'b1, 1'b1, 4'b1111, 2'b11, 400);
        compare_values(drive_ready, 1'b0, "drive idle in standby");
        hold_steady(SEL_PWROK, 1'b0, BLINK_LIMIT, "power LED steady in standby");
        wait_for_level(SEL_STANDBY, 1'b1, BLINK_LIMIT, "standby LED blink high");
        wait_for_level(SEL_STANDBY, 1'b0, BLINK_LIMIT, "standby LED blink low");
    endtask

    task automatic blink_timing();
        int gap;
        apply_reset(1'b1, 1'b1, 4'b1111, 2'b11, 400);
        wait_for_change(SEL_STANDBY, BLINK_LIMIT, "first standby LED edge", gap);
        repeat (4)
        begin
            wait_for_change(SEL_STANDBY, BLINK_LIMIT, "standby LED edge", gap);
            compare_values(gap, BLINK_STEP, "standby LED half period");
        end
        apply_reset(1'b0, 1'b0, 4'b1111, 2'b11, 400);
        hold_steady(SEL_STANDBY, 1'b1, 4 * BLINK_STEP, "standby LED quiet in emulate");
    endtask

    task automatic warm_up_delay();
        int cold;
        int warm;
        cold = rand_below(`WARM_THR2);
        warm = `WARM_THR2 + rand_below(360);
        // level 2 warm-up
        apply_reset(1'b0, 1'b0, 4'b1111, 2'b01, cold);
        wait_for_level(SEL_DELAY, 1'b0, 2 * `TEMP_POLL, "warm-up delay to start");
        compare_values(drive_ready, 1'b0, "drive held while cold");
        compare_values(temp_lo, 1'b1, "low flag while cold");
        compare_values(led_standby_n, 1'b0, "standby LED forced on while delaying");
        hold_steady(SEL_READY, 1'b0, `TEMP_POLL, "drive held during warm-up");
        @(negedge MCLK);
        model_temp = temp_code_t'(warm);
        wait_for_level(SEL_READY, 1'b1, 2 * `TEMP_POLL, "drive ready after warm-up");
        compare_values(led_delaying_n, 1'b1, "delay LED off after warm-up");
        compare_values(temp_lo, 1'b0, "low flag clear after warm-up");
    endtask

    task automatic force_start_bypass();
        int cold;
        cold = rand_below(`WARM_THR2);
        apply_reset(1'b0, 1'b0, 4'b1111, 2'b01, cold);
        wait_for_level(SEL_DELAY, 1'b0, 2 * `TEMP_POLL, "warm-up delay to start");
        force_start = 1'b1;
        @(negedge MCLK);
        force_start = 1'b0;
        wait_for_level(SEL_READY, 1'b1, 8, "drive ready after force start");
        // still cold, delay must not come back
        hold_steady(SEL_READY, 1'b1, 2 * `TEMP_POLL, "drive stays ready after force start");
        compare_values(temp_lo, 1'b1, "low flag still set after force start");
        compare_values(led_delaying_n, 1'b0, "delay LED shows cold board after force start");
    endtask

    task automatic fan_and_low_flag();
        int   t;
        logic fan_on;
        fan_on = 1'b0;
        // wide bus and fan enabled, level 3
        apply_reset(1'b0, 1'b0, 4'b0110, 2'b00, 0);
        compare_values(wide_bus_n, 1'b0, "wide bus selected");
        repeat (12)
        begin
            t = 280 + rand_below(420);
            model_temp = temp_code_t'(t);
            next_sample();
            if (t >= `FAN_THR)
                fan_on = 1'b1;
            else if (t < `FAN_THR - `FAN_HYST)
                fan_on = 1'b0;
            compare_values(fan_n, !fan_on, $sformatf("fan output at code %0d", t));
            compare_values(temp_lo, t < `WARM_THR3, $sformatf("low flag at code %0d", t));
        end
    endtask

    task automatic exit_rule_cases();
        // standby to board error
        apply_reset(1'b1, 1'b1, 4'b1111, 2'b11, 400);
        usb_pwr = 1'b0;
        wait_for_level(SEL_PWROK, 1'b1, SETTLE_LIMIT, "power LED off after leaving standby");
        wait_for_level(SEL_PWROK, 1'b0, SETTLE_LIMIT, "power LED blink low in new mode");
        wait_for_level(SEL_PWROK, 1'b1, SETTLE_LIMIT, "power LED blink high in new mode");
        hold_steady(SEL_STANDBY, 1'b1, BLINK_LIMIT, "standby LED off in board error");
        compare_values(drive_ready, 1'b0, "drive idle in board error");
        // emulate ignores input changes
        apply_reset(1'b0, 1'b0, 4'b1111, 2'b11, 400);
        usb_pwr     = 1'b1;
        board_fault = 1'b1;
        hold_steady(SEL_PWROK, 1'b0, 4 * BLINK_STEP, "power LED steady after input change");
        hold_steady(SEL_STANDBY, 1'b1, BLINK_LIMIT, "standby LED off after input change");
        compare_values(drive_ready, 1'b1, "drive ready after input change");
    endtask

    initial
    begin
        MRST        = 1'b1;
        usb_pwr     = 1'b0;
        board_fault = 1'b0;
        settings_sw = 4'b1111;
        delay_sw    = 2'b11;
        force_start = 1'b0;
        model_temp  = '0;

        mode_select_cases();
        blink_timing();
        warm_up_delay();
        force_start_bypass();
        fan_and_low_flag();
        exit_rule_cases();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/bubble_pkg.sv
hdl/mode_control.sv
hdl/status_blinker.sv
hdl/tc77_reader.sv
hdl/thermal_guard.sv
hdl/bubble_sys_top.sv
sim/tb_tc77_model.sv
sim/tb_bubble_sys.sv

// File: Bender.yml
package:
  name: bubble_sys

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bubble_pkg.sv
      - hdl/mode_control.sv
      - hdl/status_blinker.sv
      - hdl/tc77_reader.sv
      - hdl/thermal_guard.sv
      - hdl/bubble_sys_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/tb_tc77_model.sv
      - sim/tb_bubble_sys.sv
